//--- Makefile
# Verilator flow for the micro-op core and its testbench

TOP := uopCoreTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module uopCore
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- all.f
uopPkg.sv
uopDecoder.sv
uopExecute.sv
uopResult.sv
uopMemPort.sv
uopCore.sv
uopCoreTb.sv

//--- uopCore.sv
// ==========================================================================
// micro-op execution core top level
// accepts one micro-op at a time, sequences decode, execute, memory and
// retire, and reports each retired micro-op
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopCore #(
	parameter int DATA_W = 8,
	parameter int NUM_REGS = 8
) (
	input wire logic clk,
	input wire logic rstN,
	// micro-op input
	input wire logic [15:0] uopIn,
	input wire logic uopPredict,
	input wire logic uopValid,
	output logic uopReady,
	// Wishbone master
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [uopPkg::ADR_W-1:0] wbAdr,
	output logic [DATA_W-1:0] wbDatO,
	input wire logic [DATA_W-1:0] wbDatI,
	input wire logic wbAck,
	// retire report
	output logic retireValid,
	output uopPkg::uopOp_e retireOp,
	output logic retireWrite,
	output logic [uopPkg::REG_W-1:0] retireDst,
	output logic [DATA_W-1:0] retireData,
	output logic [uopPkg::FLAG_W-1:0] retireFlags,
	output logic brTaken,
	output logic brMispredict
);

	uopPkg::coreState_e state;
	logic [15:0] uReg;
	logic uPred;

	// decoded controls of the latched micro-op
	uopPkg::uopOp_e opcode;
	uopPkg::aluOp_e aluOp;
	logic [uopPkg::SRC1_W-1:0] src1Sel;
	logic [uopPkg::REG_W-1:0] src2Sel;
	logic [uopPkg::REG_W-1:0] dstSel;
	logic isLoad;
	logic isStore;
	logic isMem;
	logic isCmp;
	logic isSei;
	logic isBranch;
	logic regWrite;
	logic condTaken;

	// register file side
	logic [uopPkg::SRC1_W-1:0] rdA;
	logic [uopPkg::REG_W-1:0] rdB;
	logic [DATA_W-1:0] dataA;
	logic [DATA_W-1:0] dataB;
	logic [uopPkg::FLAG_W-1:0] flags;
	logic [DATA_W-1:0] wrData;

	// execute outputs and their retire copies
	logic [DATA_W-1:0] aluResult;
	logic [uopPkg::FLAG_W-1:0] aluFlags;
	logic exTaken;
	logic exMispredict;
	logic [DATA_W-1:0] resReg;
	logic [uopPkg::FLAG_W-1:0] flagsReg;
	logic takenReg;
	logic mispredReg;

	// memory side
	logic [uopPkg::ADR_W-1:0] memAddr;
	logic memStart;
	logic [DATA_W-1:0] memRdata;
	logic memDone;

	// ==========================================================================
	// sequencer
	// ==========================================================================
	assign uopReady = (state == uopPkg::IDLE);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= uopPkg::IDLE;
			uReg <= '0;
			uPred <= 1'b0;
		end
		else
		begin
			case (state)
			uopPkg::IDLE:
			begin
				if (uopValid)
				begin
					uReg <= uopIn;
					uPred <= uopPredict;
					state <= uopPkg::EXEC;
				end
			end
			uopPkg::EXEC: state <= isMem ? uopPkg::MEM : uopPkg::RETIRE;
			uopPkg::MEM:
			begin
				if (memDone)
					state <= uopPkg::RETIRE;
			end
			default: state <= uopPkg::IDLE;
			endcase
		end
	end

	// in IDLE the read ports look at the incoming word so the address is
	// ready at accept and in EXEC a store reads its data register on port B
	assign rdA = (state == uopPkg::IDLE) ? uopIn[9:6] : src1Sel;
	assign rdB = (state == uopPkg::IDLE) ? uopIn[2:0] : (isStore ? dstSel : src2Sel);

	// address from src1 high byte and src2 low byte
	// execute results held until retire
	always_ff @(posedge clk)
	begin
		if (state == uopPkg::IDLE)
			memAddr <= {dataA, dataB};
		if (state == uopPkg::EXEC)
		begin
			resReg <= aluResult;
			flagsReg <= aluFlags;
			takenReg <= exTaken;
			mispredReg <= exMispredict;
		end
	end

	assign memStart = (state == uopPkg::EXEC) & isMem;
	assign wrData = isLoad ? memRdata : resReg;

	// ==========================================================================
	// retire report
	// ==========================================================================
	assign retireValid = (state == uopPkg::RETIRE);
	assign retireOp = opcode;
	assign retireWrite = retireValid & regWrite;
	assign retireDst = dstSel;
	assign retireData = wrData;
	assign retireFlags = flagsReg;
	assign brTaken = retireValid & takenReg;
	assign brMispredict = retireValid & mispredReg;

	// ==========================================================================
	// blocks
	// ==========================================================================
	uopDecoder uDec (
		.instr(uReg),
		.flags(flags),
		.opcode(opcode),
		.aluOp(aluOp),
		.src1Sel(src1Sel),
		.src2Sel(src2Sel),
		.dstSel(dstSel),
		.isLoad(isLoad),
		.isStore(isStore),
		.isMem(isMem),
		.isCmp(isCmp),
		.isSei(isSei),
		.isBranch(isBranch),
		.regWrite(regWrite),
		.needFlags(),
		.branchTaken(condTaken)
	);

	uopExecute #(.DATA_W(DATA_W)) uExe (
		.aluOp(aluOp),
		.opA(dataA),
		.opB(dataB),
		.flagsIn(flags),
		.isCmp(isCmp),
		.isSei(isSei),
		.isBranch(isBranch),
		.branchTaken(condTaken),
		.predictTaken(uPred),
		.result(aluResult),
		.flagsOut(aluFlags),
		.taken(exTaken),
		.mispredict(exMispredict)
	);

	// memory ops leave the status word as it is
	uopResult #(.DATA_W(DATA_W), .NUM_REGS(NUM_REGS)) uRes (
		.clk(clk),
		.rstN(rstN),
		.rdA(rdA),
		.rdB(rdB),
		.writeEn(retireWrite),
		.flagsEn(retireValid & ~isMem),
		.wrDst(dstSel),
		.wrData(wrData),
		.flagsIn(flagsReg),
		.dataA(dataA),
		.dataB(dataB),
		.flags(flags)
	);

	uopMemPort #(.DATA_W(DATA_W)) uMem (
		.clk(clk),
		.rstN(rstN),
		.start(memStart),
		.write(isStore),
		.addr(memAddr),
		.wdata(dataB),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.rdata(memRdata),
		.done(memDone),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatO(wbDatO)
	);

endmodule

`default_nettype wire

//--- uopCoreTb.sv
// ==========================================================================
// micro-op core testbench
// drives micro-ops, models a Wishbone byte memory with random ack delay
// and checks every retire against a reference model
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopCoreTb;

	logic clk = 1'b0;
	logic rstN;
	logic [15:0] uopIn;
	logic uopPredict;
	logic uopValid;
	logic uopReady;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [15:0] wbAdr;
	logic [7:0] wbDatO;
	logic [7:0] wbDatI = 8'h00;
	logic wbAck = 1'b0;
	logic retireValid;
	uopPkg::uopOp_e retireOp;
	logic retireWrite;
	logic [2:0] retireDst;
	logic [7:0] retireData;
	logic [4:0] retireFlags;
	logic brTaken;
	logic brMispredict;

	// reference state
	logic [7:0] refRegs [8];
	logic [4:0] refFlags;
	logic [7:0] refMem [65536];
	logic refIsMem;
	logic [24:0] refBusExp;

	// expected retires as {op, write, dst, data, flags, taken, mispredict}
	logic [24:0] expQ [$];
	// accept edge per micro-op or -1 where latency varies
	int accQ [$];
	// expected bus cycles as {we, adr, dat}
	logic [24:0] busQ [$];
	int cycleCnt = 0;

	// memory model
	logic [7:0] mem [65536];
	logic inCycle = 1'b0;
	int ackDelay = 0;
	logic [15:0] heldAdr;
	logic heldWe;
	logic [7:0] heldDat;

	always #10 clk = ~clk;

	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	uopCore #(.DATA_W(8), .NUM_REGS(8)) DUT (
		.clk(clk),
		.rstN(rstN),
		.uopIn(uopIn),
		.uopPredict(uopPredict),
		.uopValid(uopValid),
		.uopReady(uopReady),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatO(wbDatO),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.retireValid(retireValid),
		.retireOp(retireOp),
		.retireWrite(retireWrite),
		.retireDst(retireDst),
		.retireData(retireData),
		.retireFlags(retireFlags),
		.brTaken(brTaken),
		.brMispredict(brMispredict)
	);

	// ==========================================================================
	// helpers
	// ==========================================================================
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			failRun($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// pattern mixes both address bytes
	function automatic logic [7:0] fillByte(input logic [15:0] a);
		return a[15:8] ^ {a[2:0], a[7:3]} ^ 8'h3C;
	endfunction

	function automatic logic [15:0] packUop(input uopPkg::uopOp_e op, input logic [3:0] s1,
		input logic [2:0] dst, input logic [2:0] s2);
		return {op, s1, dst, s2};
	endfunction

	// value producing ops for random stimulus
	function automatic uopPkg::uopOp_e aluOpAt(input int k);
		case (k)
		0:       return uopPkg::ADDB;
		1:       return uopPkg::ADCB;
		2:       return uopPkg::SBCB;
		3:       return uopPkg::ANDB;
		4:       return uopPkg::ORB;
		5:       return uopPkg::EORB;
		6:       return uopPkg::CMPB;
		7:       return uopPkg::ASLB;
		8:       return uopPkg::LSRB;
		9:       return uopPkg::ROLB;
		10:      return uopPkg::RORB;
		default: return uopPkg::MOV;
		endcase
	endfunction

	// ==========================================================================
	// reference model, one micro-op per call
	// ==========================================================================
	function automatic logic [24:0] refStep(input logic [15:0] instr, input logic pred);
		uopPkg::uopOp_e op;
		logic [2:0] dst;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] r;
		logic [4:0] f;
		logic cin;
		logic borrow;
		logic wr;
		logic br;
		logic tk;
		int u;
		int s;
		op = uopPkg::uopOp_e'(instr[15:10]);
		dst = instr[5:3];
		// src1 codes 8..15 are the immediates 0..7
		a = instr[9] ? {5'b0, instr[8:6]} : refRegs[instr[8:6]];
		b = refRegs[instr[2:0]];
		f = refFlags;
		cin = f[uopPkg::FLAG_C];
		r = a;
		tk = 1'b0;
		refIsMem = op inside {uopPkg::LDB, uopPkg::STB};
		wr = op inside {[uopPkg::LDB:uopPkg::RORB]} && op != uopPkg::STB && op != uopPkg::CMPB;
		br = op inside {[uopPkg::BEQ:uopPkg::BPL]};
		case (op)
		uopPkg::LDB:
		begin
			r = refMem[{a, b}];
			refBusExp = {1'b0, a, b, 8'h00};
		end
		uopPkg::STB:
		begin
			// store data comes from the dst register
			refMem[{a, b}] = refRegs[dst];
			refBusExp = {1'b1, a, b, refRegs[dst]};
		end
		uopPkg::ADDB, uopPkg::ADCB:
		begin
			if (op == uopPkg::ADDB)
				cin = 1'b0;
			u = int'(a) + int'(b) + int'(cin);
			s = int'($signed(a)) + int'($signed(b)) + int'(cin);
			r = u[7:0];
			f[uopPkg::FLAG_C] = (u > 255);
			f[uopPkg::FLAG_V] = (s > 127) || (s < -128);
		end
		uopPkg::SBCB, uopPkg::CMPB:
		begin
			// compare never borrows in and carry set is no borrow out
			borrow = (op == uopPkg::CMPB) ? 1'b0 : ~cin;
			u = int'(a) - int'(b) - int'(borrow);
			s = int'($signed(a)) - int'($signed(b)) - int'(borrow);
			r = u[7:0];
			f[uopPkg::FLAG_C] = (u >= 0);
			if (op == uopPkg::SBCB)
				f[uopPkg::FLAG_V] = (s > 127) || (s < -128);
		end
		uopPkg::ANDB: r = a & b;
		uopPkg::ORB:  r = a | b;
		uopPkg::EORB: r = a ^ b;
		uopPkg::ASLB:
		begin
			r = {a[6:0], 1'b0};
			f[uopPkg::FLAG_C] = a[7];
		end
		uopPkg::LSRB:
		begin
			r = {1'b0, a[7:1]};
			f[uopPkg::FLAG_C] = a[0];
		end
		uopPkg::ROLB:
		begin
			r = {a[6:0], cin};
			f[uopPkg::FLAG_C] = a[7];
		end
		uopPkg::RORB:
		begin
			r = {cin, a[7:1]};
			f[uopPkg::FLAG_C] = a[0];
		end
		uopPkg::SEI: f[uopPkg::FLAG_I] = 1'b1;
		uopPkg::BEQ: tk = f[uopPkg::FLAG_Z];
		uopPkg::BNE: tk = ~f[uopPkg::FLAG_Z];
		uopPkg::BCS: tk = f[uopPkg::FLAG_C];
		uopPkg::BCC: tk = ~f[uopPkg::FLAG_C];
		uopPkg::BVS: tk = f[uopPkg::FLAG_V];
		uopPkg::BVC: tk = ~f[uopPkg::FLAG_V];
		uopPkg::BMI: tk = f[uopPkg::FLAG_N];
		uopPkg::BPL: tk = ~f[uopPkg::FLAG_N];
		default:     tk = 1'b0;
		endcase
		// N and Z follow every value producing op
		if (op inside {[uopPkg::MOV:uopPkg::RORB]})
		begin
			f[uopPkg::FLAG_N] = r[7];
			f[uopPkg::FLAG_Z] = (r == 8'h00);
		end
		if (wr)
			refRegs[dst] = r;
		refFlags = f;
		return {op, wr, dst, r, f, tk, br & (tk != pred)};
	endfunction

	// wait for ready, queue expectations, hold valid for one edge
	task automatic issueUop(input logic [15:0] instr, input logic pred);
		int waitCnt;
		waitCnt = 0;
		while (uopReady !== 1'b1)
		begin
			if (waitCnt == 100)
				failRun("timeout waiting for uopReady");
			@(negedge clk);
			waitCnt++;
		end
		expQ.push_back(refStep(instr, pred));
		if (refIsMem)
		begin
			busQ.push_back(refBusExp);
			accQ.push_back(-1);
		end
		else
			accQ.push_back(cycleCnt + 1);
		uopIn = instr;
		uopPredict = pred;
		uopValid = 1'b1;
		@(negedge clk);
		uopValid = 1'b0;
	endtask

	// ==========================================================================
	// Wishbone memory model
	// ==========================================================================
	always @(negedge clk)
	begin : wbSlave
		logic [24:0] busExp;
		// stb rises and drops with cyc in single transfers
		if (rstN)
			checkEq("wbStb", 32'(wbStb), 32'(wbCyc));
		if (!rstN)
		begin
			wbAck = 1'b0;
			inCycle = 1'b0;
		end
		else if (wbAck)
		begin
			// transfer finished on the last rising edge
			wbAck = 1'b0;
			inCycle = 1'b0;
		end
		else if (wbCyc && wbStb)
		begin
			if (!inCycle)
			begin
				if (busQ.size() == 0)
					failRun("bus cycle started with no memory micro-op outstanding");
				else
				begin
					busExp = busQ.pop_front();
					checkEq("wbWe", 32'(wbWe), 32'(busExp[24]));
					checkEq("wbAdr", 32'(wbAdr), 32'(busExp[23:8]));
					if (busExp[24])
						checkEq("wbDatO", 32'(wbDatO), 32'(busExp[7:0]));
				end
				inCycle = 1'b1;
				heldAdr = wbAdr;
				heldWe = wbWe;
				heldDat = wbDatO;
				ackDelay = int'($urandom_range(3, 0));
			end
			else
			begin
				// master must hold the cycle until ack
				checkEq("wbAdr", 32'(wbAdr), 32'(heldAdr));
				checkEq("wbWe", 32'(wbWe), 32'(heldWe));
				checkEq("wbDatO", 32'(wbDatO), 32'(heldDat));
			end
			if (ackDelay == 0)
			begin
				if (wbWe)
					mem[wbAdr] = wbDatO;
				else
					wbDatI = mem[wbAdr];
				wbAck = 1'b1;
			end
			else
				ackDelay--;
		end
	end

	// ==========================================================================
	// retire checker
	// ==========================================================================
	always @(negedge clk)
	begin : retireCheck
		logic [24:0] e;
		int acc;
		if (rstN && retireValid)
		begin
			if (expQ.size() == 0)
				failRun("retire seen with no micro-op outstanding");
			else
			begin
				e = expQ.pop_front();
				acc = accQ.pop_front();
				checkEq("retireOp", 32'(retireOp), 32'(e[24:19]));
				checkEq("retireWrite", 32'(retireWrite), 32'(e[18]));
				checkEq("retireDst", 32'(retireDst), 32'(e[17:15]));
				if (e[18])
					checkEq("retireData", 32'(retireData), 32'(e[14:7]));
				checkEq("retireFlags", 32'(retireFlags), 32'(e[6:2]));
				checkEq("brTaken", 32'(brTaken), 32'(e[1]));
				checkEq("brMispredict", 32'(brMispredict), 32'(e[0]));
				// non-memory ops retire a fixed two edges after accept
				if (acc >= 0)
					checkEq("retireLatency", 32'(cycleCnt + 1 - acc), 32'd2);
			end
		end
	end

	// ==========================================================================
	// stimulus
	// ==========================================================================
	initial
	begin
		logic [15:0] fillAdr;
		logic [31:0] rnd;
		int waitCnt;
		void'($urandom(32'h4154));
		rstN = 1'b0;
		uopIn = 16'h0000;
		uopPredict = 1'b0;
		uopValid = 1'b0;
		for (int i = 0; i < 8; i++)
			refRegs[i] = 8'h00;
		refFlags = 5'b0;
		for (int i = 0; i < 65536; i++)
		begin
			fillAdr = 16'(i);
			mem[fillAdr] = fillByte(fillAdr);
			refMem[fillAdr] = mem[fillAdr];
		end
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		// idle after reset
		checkEq("uopReady", 32'(uopReady), 32'd1);
		checkEq("wbCyc", 32'(wbCyc), 32'd0);
		checkEq("wbStb", 32'(wbStb), 32'd0);
		checkEq("retireValid", 32'(retireValid), 32'd0);

		// immediates into every register
		for (int k = 0; k < 8; k++)
			issueUop(packUop(uopPkg::MOV, 4'(8 + k), k[2:0], 3'd0), 1'b0);

		// loads give the registers wider values before the random ALU ops
		for (int k = 0; k < 8; k++)
		begin
			rnd = $urandom;
			issueUop(packUop(uopPkg::LDB, rnd[3:0], k[2:0], rnd[6:4]), 1'b0);
		end
		for (int k = 0; k < 200; k++)
		begin
			rnd = $urandom;
			issueUop(packUop(aluOpAt(int'(rnd[7:0]) % 12), rnd[11:8], rnd[14:12], rnd[17:15]),
				1'b0);
		end

		// store then load back from the same address
		for (int k = 0; k < 40; k++)
		begin
			rnd = $urandom;
			issueUop(packUop(uopPkg::STB, rnd[3:0], rnd[6:4], rnd[9:7]), 1'b0);
			issueUop(packUop(uopPkg::LDB, rnd[3:0], rnd[12:10], rnd[9:7]), 1'b0);
		end

		// every branch after a flag setting op
		for (int k = 0; k < 16; k++)
		begin
			rnd = $urandom;
			issueUop(packUop(aluOpAt(int'(rnd[7:0]) % 12), rnd[11:8], rnd[14:12], rnd[17:15]),
				1'b0);
			for (int b = 0; b < 8; b++)
			begin
				rnd = $urandom;
				issueUop(packUop(uopPkg::uopOp_e'(6'(int'(uopPkg::BEQ) + b)), rnd[3:0],
					rnd[6:4], rnd[9:7]), rnd[10]);
			end
		end

		// I stays set through later ops
		issueUop(packUop(uopPkg::SEI, 4'd0, 3'd0, 3'd0), 1'b0);
		for (int k = 0; k < 20; k++)
		begin
			rnd = $urandom;
			issueUop(packUop(aluOpAt(int'(rnd[7:0]) % 12), rnd[11:8], rnd[14:12], rnd[17:15]),
				1'b0);
		end

		// drain outstanding retires
		waitCnt = 0;
		while (expQ.size() != 0 && waitCnt < 100)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (expQ.size() != 0)
			failRun("timeout waiting for the last retire");
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- uopDecoder.sv
// ==========================================================================
// micro-op decoder
// classifies a 16-bit micro-op into control signals and resolves the
// branch condition against the current status flags
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopDecoder (
	input wire logic [15:0] instr,
	input wire logic [uopPkg::FLAG_W-1:0] flags,
	output uopPkg::uopOp_e opcode,
	output uopPkg::aluOp_e aluOp,
	output logic [uopPkg::SRC1_W-1:0] src1Sel,
	output logic [uopPkg::REG_W-1:0] src2Sel,
	output logic [uopPkg::REG_W-1:0] dstSel,
	output logic isLoad,
	output logic isStore,
	output logic isMem,
	output logic isCmp,
	output logic isSei,
	output logic isBranch,
	output logic regWrite,
	output logic needFlags,
	output logic branchTaken
);

	// operand fields
	assign src1Sel = instr[9:6];
	assign dstSel = instr[5:3];
	assign src2Sel = instr[2:0];

	// opcode field with unassigned codes folded to NOP
	always_comb
	begin
		if (instr[15:10] <= 6'(uopPkg::BPL))
			opcode = uopPkg::uopOp_e'(instr[15:10]);
		else
			opcode = uopPkg::NOP;
	end

	// execute operation select
	// compare shares the subtract path and execute forces the borrow
	always_comb
	begin
		case (opcode)
		uopPkg::MOV:  aluOp = uopPkg::ALU_MOV;
		uopPkg::ADDB: aluOp = uopPkg::ALU_ADD;
		uopPkg::ADCB: aluOp = uopPkg::ALU_ADC;
		uopPkg::SBCB: aluOp = uopPkg::ALU_SBC;
		uopPkg::CMPB: aluOp = uopPkg::ALU_SBC;
		uopPkg::ANDB: aluOp = uopPkg::ALU_AND;
		uopPkg::ORB:  aluOp = uopPkg::ALU_OR;
		uopPkg::EORB: aluOp = uopPkg::ALU_EOR;
		uopPkg::ASLB: aluOp = uopPkg::ALU_ASL;
		uopPkg::LSRB: aluOp = uopPkg::ALU_LSR;
		uopPkg::ROLB: aluOp = uopPkg::ALU_ROL;
		uopPkg::RORB: aluOp = uopPkg::ALU_ROR;
		default:      aluOp = uopPkg::ALU_NOP;
		endcase
	end

	// class bits
	assign isLoad = (opcode == uopPkg::LDB);
	assign isStore = (opcode == uopPkg::STB);
	assign isMem = isLoad | isStore;
	assign isCmp = (opcode == uopPkg::CMPB);
	assign isSei = (opcode == uopPkg::SEI);
	// predictable branches only
	assign isBranch = opcode inside {[uopPkg::BEQ:uopPkg::BPL]};

	// loads and every value-producing op except compare write a register
	assign regWrite = isLoad | ((aluOp != uopPkg::ALU_NOP) & ~isCmp);

	// carry consumers and branches read the status word
	assign needFlags = isBranch |
		(opcode inside {uopPkg::ADCB, uopPkg::SBCB, uopPkg::ROLB, uopPkg::RORB});

	// branch condition tests one flag for true or false
	always_comb
	begin
		case (opcode)
		uopPkg::BEQ: branchTaken = flags[uopPkg::FLAG_Z];
		uopPkg::BNE: branchTaken = ~flags[uopPkg::FLAG_Z];
		uopPkg::BCS: branchTaken = flags[uopPkg::FLAG_C];
		uopPkg::BCC: branchTaken = ~flags[uopPkg::FLAG_C];
		uopPkg::BVS: branchTaken = flags[uopPkg::FLAG_V];
		uopPkg::BVC: branchTaken = ~flags[uopPkg::FLAG_V];
		uopPkg::BMI: branchTaken = flags[uopPkg::FLAG_N];
		uopPkg::BPL: branchTaken = ~flags[uopPkg::FLAG_N];
		default:     branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- uopExecute.sv
// ==========================================================================
// micro-op execute block
// byte ALU, compare, shifts and rotates, SEI, new status flags and
// branch direction against prediction
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopExecute #(
	parameter int DATA_W = 8
) (
	input wire uopPkg::aluOp_e aluOp,
	input wire logic [DATA_W-1:0] opA,
	input wire logic [DATA_W-1:0] opB,
	input wire logic [uopPkg::FLAG_W-1:0] flagsIn,
	input wire logic isCmp,
	input wire logic isSei,
	input wire logic isBranch,
	input wire logic branchTaken,
	input wire logic predictTaken,
	output logic [DATA_W-1:0] result,
	output logic [uopPkg::FLAG_W-1:0] flagsOut,
	output logic taken,
	output logic mispredict
);

	localparam int MSB = DATA_W - 1;

	logic carryIn;
	logic isSub;
	logic addCin;
	logic [DATA_W-1:0] addB;
	logic [DATA_W:0] sum;
	logic overflow;
	logic updNZ;

	// ==========================================================================
	// adder shared by add, add with carry, subtract and compare
	// ==========================================================================
	always_comb
	begin
		carryIn = flagsIn[uopPkg::FLAG_C];
		isSub = (aluOp == uopPkg::ALU_SBC);
		// subtract is opA + ~opB + carry and carry set means no borrow
		addB = isSub ? ~opB : opB;
		if (isSub)
			addCin = isCmp ? 1'b1 : carryIn;
		else
			addCin = (aluOp == uopPkg::ALU_ADC) ? carryIn : 1'b0;
		sum = {1'b0, opA} + {1'b0, addB} + {{DATA_W{1'b0}}, addCin};
		// signed overflow when operands agree in sign and the sum does not
		overflow = (opA[MSB] == addB[MSB]) && (sum[MSB] != opA[MSB]);
	end

	// ==========================================================================
	// result and flags
	// ==========================================================================
	always_comb
	begin
		result = opA;
		flagsOut = flagsIn;
		updNZ = 1'b1;
		case (aluOp)
		uopPkg::ALU_ADD, uopPkg::ALU_ADC, uopPkg::ALU_SBC:
		begin
			result = sum[MSB:0];
			flagsOut[uopPkg::FLAG_C] = sum[DATA_W];
			// compare leaves V as it was
			if (!isCmp)
				flagsOut[uopPkg::FLAG_V] = overflow;
		end
		uopPkg::ALU_AND: result = opA & opB;
		uopPkg::ALU_OR:  result = opA | opB;
		uopPkg::ALU_EOR: result = opA ^ opB;
		uopPkg::ALU_MOV: result = opA;
		uopPkg::ALU_ASL:
		begin
			result = {opA[MSB-1:0], 1'b0};
			flagsOut[uopPkg::FLAG_C] = opA[MSB];
		end
		uopPkg::ALU_LSR:
		begin
			result = {1'b0, opA[MSB:1]};
			flagsOut[uopPkg::FLAG_C] = opA[0];
		end
		uopPkg::ALU_ROL:
		begin
			result = {opA[MSB-1:0], carryIn};
			flagsOut[uopPkg::FLAG_C] = opA[MSB];
		end
		uopPkg::ALU_ROR:
		begin
			result = {carryIn, opA[MSB:1]};
			flagsOut[uopPkg::FLAG_C] = opA[0];
		end
		// loads, stores, branches, SEI and NOP
		default: updNZ = 1'b0;
		endcase

		if (updNZ)
		begin
			flagsOut[uopPkg::FLAG_N] = result[MSB];
			flagsOut[uopPkg::FLAG_Z] = (result == '0);
		end

		// interrupt disable only ever gets set here
		if (isSei)
			flagsOut[uopPkg::FLAG_I] = 1'b1;
	end

	// branch outcome with the condition already resolved in the decoder
	assign taken = isBranch & branchTaken;
	assign mispredict = isBranch & (taken != predictTaken);

endmodule

`default_nettype wire

//--- uopMemPort.sv
// ==========================================================================
// Wishbone classic master for byte loads and stores
// one cycle per start, read data captured at ack, done pulses once
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopMemPort #(
	parameter int DATA_W = 8
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic start,
	input wire logic write,
	input wire logic [uopPkg::ADR_W-1:0] addr,
	input wire logic [DATA_W-1:0] wdata,
	input wire logic [DATA_W-1:0] wbDatI,
	input wire logic wbAck,
	output logic [DATA_W-1:0] rdata,
	output logic done,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [uopPkg::ADR_W-1:0] wbAdr,
	output logic [DATA_W-1:0] wbDatO
);

	logic busy;

	// cyc and stb move together in classic single transfers
	assign wbCyc = busy;
	assign wbStb = busy;

	// bus handshake
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			wbWe <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (busy)
			begin
				// slave accepted so the cycle drops next
				if (wbAck)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
			else if (start)
			begin
				busy <= 1'b1;
				wbWe <= write;
			end
		end
	end

	// address and write data held stable for the whole cycle
	always_ff @(posedge clk)
	begin
		if (!busy && start)
		begin
			wbAdr <= addr;
			wbDatO <= wdata;
		end
		if (busy && wbAck)
			rdata <= wbDatI;
	end

endmodule

`default_nettype wire

//--- uopPkg.sv
// ==========================================================================
// micro-op core shared definitions
// opcode, sequencer and ALU operation enums, flag positions, field widths
// ==========================================================================
`default_nettype none

package uopPkg;

	// micro-op field widths
	// word layout is opcode, src1, dst, src2 from msb down
	localparam int OPC_W = 6;
	localparam int SRC1_W = 4;
	localparam int REG_W = 3;
	localparam int ADR_W = 16;

	// status word layout
	localparam int FLAG_W = 5;
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_I = 2;
	localparam int FLAG_V = 3;
	localparam int FLAG_N = 4;

	// micro-op codes
	// codes above BPL are unassigned and run as NOP
	typedef enum logic [OPC_W-1:0] {
		NOP  = 6'h00,
		LDB  = 6'h01,
		STB  = 6'h02,
		MOV  = 6'h03,
		ADDB = 6'h04,
		ADCB = 6'h05,
		SBCB = 6'h06,
		ANDB = 6'h07,
		ORB  = 6'h08,
		EORB = 6'h09,
		CMPB = 6'h0A,
		ASLB = 6'h0B,
		LSRB = 6'h0C,
		ROLB = 6'h0D,
		RORB = 6'h0E,
		SEI  = 6'h0F,
		BEQ  = 6'h10,
		BNE  = 6'h11,
		BCS  = 6'h12,
		BCC  = 6'h13,
		BVS  = 6'h14,
		BVC  = 6'h15,
		BMI  = 6'h16,
		BPL  = 6'h17
	} uopOp_e;

	// sequencer states
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		MEM,
		RETIRE
	} coreState_e;

	// execute block operation
	// ALU_NOP passes opA and leaves every flag alone
	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_MOV,
		ALU_ADD,
		ALU_ADC,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_ASL,
		ALU_LSR,
		ALU_ROL,
		ALU_ROR
	} aluOp_e;

endpackage

`default_nettype wire

//--- uopResult.sv
// ==========================================================================
// micro-op result block
// byte register file with two read ports and the status register,
// both written on the retire edge
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module uopResult #(
	parameter int DATA_W = 8,
	parameter int NUM_REGS = 8
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [uopPkg::SRC1_W-1:0] rdA,
	input wire logic [uopPkg::REG_W-1:0] rdB,
	input wire logic writeEn,
	input wire logic flagsEn,
	input wire logic [uopPkg::REG_W-1:0] wrDst,
	input wire logic [DATA_W-1:0] wrData,
	input wire logic [uopPkg::FLAG_W-1:0] flagsIn,
	output logic [DATA_W-1:0] dataA,
	output logic [DATA_W-1:0] dataB,
	output logic [uopPkg::FLAG_W-1:0] flags
);

	logic [DATA_W-1:0] regs [NUM_REGS];
	logic [uopPkg::REG_W-1:0] regA;

	// low bits select a register or give the immediate value
	assign regA = rdA[uopPkg::REG_W-1:0];

	// codes 8..15 read back as the constants 0..7
	assign dataA = rdA[uopPkg::SRC1_W-1] ? DATA_W'(regA) : regs[regA];
	assign dataB = regs[rdB];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
			flags <= '0;
		end
		else
		begin
			if (writeEn)
				regs[wrDst] <= wrData;
			if (flagsEn)
				flags <= flagsIn;
		end
	end

endmodule

`default_nettype wire
